//--- mem_stage.f
hw/rvseed_pkg.sv
hw/mem_req_if.sv
hw/load_extend.sv
hw/load_unit.sv
hw/read_port.sv
hw/mem_stage_top.sv
verification/tb_mem_responder.sv
verification/tb_mem_stage.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mem_stage \
    -f mem_stage.f --Mdir obj_dir -o sim_mem_stage

./obj_dir/sim_mem_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run_sim: failures reported"
    exit 1
fi
if ! grep -qx "Simulation PASSED" sim.log; then
    echo "run_sim: simulation ended without a result"
    exit 1
fi
echo "run_sim: done"

//--- verification/tb_mem_stage.sv
`timescale 1ns/1ns

module tb_mem_stage;

    // about 14 cycles per load worst case, plus idle gap and dropped pulse
    localparam int          num_loads   = 200;
    localparam int          max_cycles  = num_loads * 20;
    localparam logic [15:0] lfsr_seed   = 16'd22424;
    // 512 byte aligned window of 64 doublewords
    localparam logic [63:0] window_base = 64'h0000_0000_8000_0000;

    typedef struct packed {
        logic [63:0] addr;
        logic [1:0]  size;
        logic        uns;
        int          start;
    } load_t;

    logic                            clk;
    logic                            rst_n;
    logic                            ld_valid;
    logic [1:0]                      ld_size;
    logic                            ld_unsigned;
    logic [rvseed_pkg::xlen-1:0]     base;
    logic [rvseed_pkg::xlen-1:0]     offset;
    logic [rvseed_pkg::xlen-1:0]     ex_result;
    logic                            busy;
    logic                            res_valid;
    logic [rvseed_pkg::xlen-1:0]     wb_result;
    logic                            ar_valid;
    logic                            ar_ready;
    logic [rvseed_pkg::xlen-1:0]     ar_addr;
    logic [rvseed_pkg::id_width-1:0] ar_id;
    logic                            r_valid;
    logic [rvseed_pkg::id_width-1:0] r_id;
    logic [rvseed_pkg::xlen-1:0]     r_data;

    logic [15:0]  lfsr;
    load_t        pend[$];
    load_t        cur;
    logic [63:0]  exp_value;
    logic         exp_busy;
    logic [63:0]  held_addr;
    logic [3:0]   held_id;
    logic         held = 1'b0;
    logic         good;
    int           cycles = 0;
    int           last_hit = -10;
    int           results_seen = 0;
    int           passed = 0;
    int           errors = 0;

    mem_stage_top i_dut (.*);
    tb_mem_responder #(.seed(lfsr_seed)) i_resp (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // expected load value by shift and mask of the whole doubleword
    function automatic logic [63:0] ref_load(input logic [63:0] addr, input logic [1:0] size,
                                             input logic uns, input logic [63:0] dw);
        logic [63:0] shifted;
        logic [63:0] mask;
        logic [63:0] val;
        int          nbits;
        shifted = dw >> (8 * addr[2:0]);
        nbits = 8 << size;
        if (nbits == 64) begin
            return shifted;
        end
        mask = (64'd1 << nbits) - 64'd1;
        val = shifted & mask;
        if (!uns && val[nbits-1]) begin
            val = val | ~mask;
        end
        return val;
    endfunction

    initial begin
        logic [63:0] r;
        logic [8:0]  off9;
        logic [63:0] sum;
        load_t       ld;
        lfsr = lfsr_seed;
        rst_n = 1'b0;
        ld_valid = 1'b0;
        ld_size = 2'd0;
        ld_unsigned = 1'b0;
        base = '0;
        offset = '0;
        ex_result = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        assert (!busy && !ar_valid && !res_valid) else begin
            errors++;
            $display("busy, ar_valid or res_valid not low during reset");
        end
        rst_n = 1'b1;
        for (int n = 0; n < num_loads; n++) begin
            r = take_bits(3);
            ld_size = r[1:0];
            ld_unsigned = r[2];
            // dword index and lane aligned to the size
            r = take_bits(9);
            off9 = r[8:0] & ~((9'd1 << ld_size) - 9'd1);
            sum = window_base + {55'd0, off9};
            offset = take_bits(64);
            base = sum - offset;
            ex_result = take_bits(64);
            ld_valid = 1'b1;
            ld.addr = sum;
            ld.size = ld_size;
            ld.uns = ld_unsigned;
            ld.start = cycles + 1;
            pend.push_back(ld);
            @(negedge clk);
            ld_valid = 1'b0;
            r = take_bits(2);
            if (r[1:0] == 2'd0) begin
                // arrives while busy and must be dropped
                // fresh offset and signedness expose a pulse that was taken
                offset = take_bits(64);
                ld_unsigned = !ld_unsigned;
                ld_valid = 1'b1;
                @(negedge clk);
                ld_valid = 1'b0;
            end
            while (results_seen <= n) begin
                @(negedge clk);
                ex_result = take_bits(64);
            end
            r = take_bits(2);
            repeat (r[1:0]) @(negedge clk);
        end
        repeat (8) @(negedge clk);
        assert (results_seen == num_loads && pend.size() == 0) else begin
            errors++;
            $display("got %0d results for %0d loads", results_seen, num_loads);
        end
        $display("loads %0d, passed %0d, errors %0d", num_loads, passed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // outputs sampled on the rising edge while inputs move on the falling one
    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("Simulation FAILED");
            $finish;
        end else if (rst_n) begin
            // busy from the cycle after the start up to the result cycle
            exp_busy = pend.size() != 0 && cycles > pend[0].start && !res_valid;
            assert (busy == exp_busy) else begin
                errors++;
                $display("FAIL %0t: busy %b, expected %b", $time, busy, exp_busy);
            end
            if (res_valid) begin
                assert (pend.size() != 0) else begin
                    errors++;
                    $display("result pulse at cycle %0d with no load outstanding", cycles);
                end
                if (pend.size() != 0) begin
                    cur = pend.pop_front();
                    exp_value = ref_load(cur.addr, cur.size, cur.uns,
                                         i_resp.peek(cur.addr[8:3]));
                    good = 1'b1;
                    assert (wb_result == exp_value) else begin
                        good = 1'b0;
                        errors++;
                        $display("FAIL %0t: load %0d wb_result %h, expected %h",
                                 $time, results_seen, wb_result, exp_value);
                    end
                    assert (cycles - cur.start >= 4) else begin
                        good = 1'b0;
                        errors++;
                        $display("load %0d finished too early", results_seen);
                    end
                    assert (cycles == last_hit + 2) else begin
                        good = 1'b0;
                        errors++;
                        $display("load %0d result did not follow a load id beat", results_seen);
                    end
                    if (good) begin
                        passed++;
                    end
                    $display("load %0d addr %h size %0d %s -> %h %s", results_seen,
                             cur.addr, cur.size, cur.uns ? "u" : "s", wb_result,
                             good ? "ok" : "bad");
                end
                results_seen++;
            end else begin
                assert (wb_result == ex_result) else begin
                    errors++;
                    $display("FAIL %0t: wb_result %h, expected ex_result %h",
                             $time, wb_result, ex_result);
                end
            end
            if (ar_valid && ar_ready && pend.size() != 0) begin
                assert (ar_id == rvseed_pkg::load_id
                        && ar_addr == {pend[0].addr[63:3], 3'b000}) else begin
                    errors++;
                    $display("FAIL %0t: request id %0d addr %h", $time, ar_id, ar_addr);
                end
            end
            // request must hold while ar_ready is low
            if (held) begin
                assert (ar_valid && ar_addr == held_addr && ar_id == held_id) else begin
                    errors++;
                    $display("FAIL %0t: request changed while stalled", $time);
                end
            end
            held = ar_valid && !ar_ready;
            held_addr = ar_addr;
            held_id = ar_id;
            if (r_valid && r_id == rvseed_pkg::load_id) begin
                last_hit = cycles;
            end
        end
    end

endmodule

//--- verification/tb_mem_responder.sv
`timescale 1ns/1ns

module tb_mem_responder #(
    parameter logic [15:0] seed = 16'd1
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            ar_valid,
    output logic                            ar_ready,
    input  logic [rvseed_pkg::xlen-1:0]     ar_addr,
    output logic                            r_valid,
    output logic [rvseed_pkg::id_width-1:0] r_id,
    output logic [rvseed_pkg::xlen-1:0]     r_data
);

    // id of the fetch side, used for stray beats
    localparam logic [rvseed_pkg::id_width-1:0] stray_id = 4'd1;

    logic [63:0] mem [64];
    logic [15:0] lfsr;

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit
    function logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function logic [63:0] peek(input logic [5:0] idx);
        return mem[idx];
    endfunction

    initial begin
        logic [63:0] r;
        logic [5:0]  idx;
        int          gap;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_id     = '0;
        r_data   = '0;
        lfsr     = seed;
        for (int i = 0; i < 64; i++) begin
            mem[i] = take_bits(64);
        end
        forever begin
            @(negedge clk);
            if (rst_n && ar_valid) begin
                // hold the request back 0 to 3 cycles
                r = take_bits(2);
                repeat (r[1:0]) @(negedge clk);
                idx = ar_addr[8:3];
                ar_ready = 1'b1;
                @(negedge clk);
                ar_ready = 1'b0;
                // beat 1 to 4 cycles after the handshake, bit 2 asks for a stray
                r = take_bits(3);
                gap = int'(r[1:0]) + 1;
                for (int s = 1; s <= gap; s++) begin
                    if (s == gap) begin
                        r_valid = 1'b1;
                        r_id    = rvseed_pkg::load_id;
                        r_data  = mem[idx];
                    end else if (r[2] && s == 1) begin
                        r_valid = 1'b1;
                        r_id    = stray_id;
                        r_data  = take_bits(64);
                    end else begin
                        r_valid = 1'b0;
                    end
                    @(negedge clk);
                end
                r_valid = 1'b0;
            end
        end
    end

endmodule

//--- hw/mem_stage_top.sv
`timescale 1ns/1ns

module mem_stage_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            ld_valid,
    input  logic [1:0]                      ld_size,
    input  logic                            ld_unsigned,
    input  logic [rvseed_pkg::xlen-1:0]     base,
    input  logic [rvseed_pkg::xlen-1:0]     offset,
    input  logic [rvseed_pkg::xlen-1:0]     ex_result,
    output logic                            busy,
    output logic                            res_valid,
    output logic [rvseed_pkg::xlen-1:0]     wb_result,
    output logic                            ar_valid,
    input  logic                            ar_ready,
    output logic [rvseed_pkg::xlen-1:0]     ar_addr,
    output logic [rvseed_pkg::id_width-1:0] ar_id,
    input  logic                            r_valid,
    input  logic [rvseed_pkg::id_width-1:0] r_id,
    input  logic [rvseed_pkg::xlen-1:0]     r_data
);

    // sequencer to bus port link
    mem_req_if req_bus ();

    // load sequencer with extension and write-back mux
    load_unit i_load_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .ld_valid    (ld_valid),
        .ld_size     (ld_size),
        .ld_unsigned (ld_unsigned),
        .base        (base),
        .offset      (offset),
        .ex_result   (ex_result),
        .busy        (busy),
        .res_valid   (res_valid),
        .wb_result   (wb_result),
        .req         (req_bus)
    );

    // bus side read channel
    read_port i_read_port (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req_bus),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_addr  (ar_addr),
        .ar_id    (ar_id),
        .r_valid  (r_valid),
        .r_id     (r_id),
        .r_data   (r_data)
    );

endmodule

//--- hw/read_port.sv
`timescale 1ns/1ns

module read_port (
    input  logic                            clk,
    input  logic                            rst_n,
    mem_req_if.bus_side                     req,
    output logic                            ar_valid,
    input  logic                            ar_ready,
    output logic [rvseed_pkg::xlen-1:0]     ar_addr,
    output logic [rvseed_pkg::id_width-1:0] ar_id,
    input  logic                            r_valid,
    input  logic [rvseed_pkg::id_width-1:0] r_id,
    input  logic [rvseed_pkg::xlen-1:0]     r_data
);

    logic                   beat_hit;
    logic                   done_q;
    rvseed_pkg::load_data_u rdata_q;

    // request held by the sequencer until accepted
    assign ar_valid = req.req_valid;
    // bus works on whole doublewords
    assign ar_addr  = {req.req_addr[rvseed_pkg::xlen-1:rvseed_pkg::lane_bits],
                       {rvseed_pkg::lane_bits{1'b0}}};
    assign ar_id    = rvseed_pkg::load_id;

    assign req.accepted = ar_valid && ar_ready;

    // beats for fetch share the channel, skip them
    assign beat_hit = r_valid && (r_id == rvseed_pkg::load_id);

    // r_ready is tied high on the bus side, so every beat is taken
    always_ff @(posedge clk) begin
        if (beat_hit) begin
            rdata_q.dword <= r_data;
        end
    end

    // done lines up with the registered data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= beat_hit;
        end
    end

    assign req.done  = done_q;
    assign req.rdata = rdata_q;

    // address channel must hold while stalled
    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (ar_valid && !ar_ready) |=> (ar_valid && $stable(ar_addr) && $stable(ar_id)))
        else $error("read address changed while stalled");

endmodule

//--- hw/load_unit.sv
`timescale 1ns/1ns

module load_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        ld_valid,
    input  logic [1:0]                  ld_size,
    input  logic                        ld_unsigned,
    input  logic [rvseed_pkg::xlen-1:0] base,
    input  logic [rvseed_pkg::xlen-1:0] offset,
    input  logic [rvseed_pkg::xlen-1:0] ex_result,
    output logic                        busy,
    output logic                        res_valid,
    output logic [rvseed_pkg::xlen-1:0] wb_result,
    mem_req_if.lsu_side                 req
);

    logic [1:0]                  state;
    logic [1:0]                  next_state;
    logic [rvseed_pkg::xlen-1:0] addr_q;
    logic [1:0]                  size_q;
    logic                        unsigned_q;
    logic                        start;
    logic                        misaligned;
    logic [rvseed_pkg::xlen-1:0] ext_value;

    // busy covers request and wait only
    // finish is already free for the next load
    assign busy = (state == rvseed_pkg::st_request) || (state == rvseed_pkg::st_wait);

    // pulses during busy are simply dropped
    assign start = ld_valid && !busy;

    always_comb begin
        next_state = state;
        case (state)
            rvseed_pkg::st_idle: begin
                if (start) begin
                    next_state = rvseed_pkg::st_request;
                end
            end
            rvseed_pkg::st_request: begin
                // stay until the address channel takes it
                if (req.accepted) begin
                    next_state = rvseed_pkg::st_wait;
                end
            end
            rvseed_pkg::st_wait: begin
                if (req.done) begin
                    next_state = rvseed_pkg::st_finish;
                end
            end
            default: begin
                // back to back load may start here
                next_state = start ? rvseed_pkg::st_request : rvseed_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rvseed_pkg::st_idle;
        end else begin
            state <= next_state;
        end
    end

    // effective address and access kind, captured on start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q     <= '0;
            size_q     <= rvseed_pkg::ls_byte;
            unsigned_q <= 1'b0;
        end else if (start) begin
            addr_q     <= base + offset;
            size_q     <= ld_size;
            unsigned_q <= ld_unsigned;
        end
    end

    assign req.req_valid = (state == rvseed_pkg::st_request);
    assign req.req_addr  = addr_q;

    // lane from the low address bits
    load_extend i_extend (
        .beat        (req.rdata),
        .lane        (addr_q[rvseed_pkg::lane_bits-1:0]),
        .size        (size_q),
        .is_unsigned (unsigned_q),
        .value       (ext_value)
    );

    // one cycle result, otherwise pass the execute result through
    assign res_valid = (state == rvseed_pkg::st_finish);
    assign wb_result = res_valid ? ext_value : ex_result;

    // natural alignment per size
    always_comb begin
        case (size_q)
            rvseed_pkg::ls_byte: misaligned = 1'b0;
            rvseed_pkg::ls_half: misaligned = addr_q[0];
            rvseed_pkg::ls_word: misaligned = |addr_q[1:0];
            default:             misaligned = |addr_q[2:0];
        endcase
    end

    // a misaligned load would need two beats
    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (state == rvseed_pkg::st_request) |-> !misaligned)
        else $error("misaligned load address %h size %0d", addr_q, size_q);

    // read port must not report a beat nobody is waiting for
    a_done_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        req.done |-> (state == rvseed_pkg::st_wait))
        else $error("done pulse outside the wait state");

endmodule

//--- hw/load_extend.sv
`timescale 1ns/1ns

module load_extend (
    input  rvseed_pkg::load_data_u             beat,
    input  logic [rvseed_pkg::lane_bits-1:0]   lane,
    input  logic [1:0]                         size,
    input  logic                               is_unsigned,
    output logic [rvseed_pkg::xlen-1:0]        value
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    logic [31:0] word_lane;
    logic        byte_fill;
    logic        half_fill;
    logic        word_fill;

    // lane picks straight from the union views
    assign byte_lane = beat.bytes[lane];
    // halves and words ignore the low offset bits,
    // alignment is checked in the sequencer
    assign half_lane = beat.halves[lane[2:1]];
    assign word_lane = beat.words[lane[2]];

    // fill bit: lane msb for signed loads, zero otherwise
    assign byte_fill = !is_unsigned && byte_lane[7];
    assign half_fill = !is_unsigned && half_lane[15];
    assign word_fill = !is_unsigned && word_lane[31];

    always_comb begin
        case (size)
            rvseed_pkg::ls_byte: begin
                value = {{(rvseed_pkg::xlen-8){byte_fill}}, byte_lane};
            end
            rvseed_pkg::ls_half: begin
                value = {{(rvseed_pkg::xlen-16){half_fill}}, half_lane};
            end
            rvseed_pkg::ls_word: begin
                value = {{(rvseed_pkg::xlen-32){word_fill}}, word_lane};
            end
            default: begin
                // ld, nothing to extend
                value = beat.dword;
            end
        endcase
    end

endmodule

//--- hw/mem_req_if.sv
`timescale 1ns/1ns

interface mem_req_if;

    // request pending, held until accepted
    logic                            req_valid;
    // byte address of the load
    logic [rvseed_pkg::xlen-1:0]     req_addr;
    // address handshake done this cycle
    logic                            accepted;
    // matching beat stored, one cycle pulse
    logic                            done;
    // stored beat, valid from done on
    rvseed_pkg::load_data_u          rdata;

    // sequencer end
    modport lsu_side (
        output req_valid,
        output req_addr,
        input  accepted,
        input  done,
        input  rdata
    );

    // bus end
    modport bus_side (
        input  req_valid,
        input  req_addr,
        output accepted,
        output done,
        output rdata
    );

endinterface

//--- hw/rvseed_pkg.sv
package rvseed_pkg;

    // data path and address width of the core
    localparam int xlen = 64;

    // byte offset bits inside one doubleword beat
    localparam int lane_bits = 3;

    // access size codes, as carried on ld_size
    localparam logic [1:0] ls_byte  = 2'd0;
    localparam logic [1:0] ls_half  = 2'd1;
    localparam logic [1:0] ls_word  = 2'd2;
    localparam logic [1:0] ls_dword = 2'd3;

    // bus id field
    localparam int id_width = 4;

    // id owned by the load stage
    // fetch uses the other ids on the same bus
    localparam logic [id_width-1:0] load_id = 4'd2;

    // load sequencer states
    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_request = 2'd1;
    localparam logic [1:0] st_wait    = 2'd2;
    localparam logic [1:0] st_finish  = 2'd3;

    // one returned read beat
    // every view covers the same 64 bits, lowest lane at index 0
    typedef union packed {
        // whole beat, for ld
        logic [xlen-1:0]   dword;
        // two words, for lw / lwu
        logic [1:0][31:0]  words;
        // four halves, for lh / lhu
        logic [3:0][15:0]  halves;
        // eight bytes, for lb / lbu
        logic [7:0][7:0]   bytes;
    } load_data_u;

endpackage
